// File: src/rename_pkg.sv
// rename and retire package, shared widths, tag and index types, branch outcome encoding
package rename_pkg;

	// --------------------
	// default sizes, top level passes them down
	localparam int NUM_PHYS_DEF  = 48;
	localparam int NUM_ARCH_DEF  = 32;
	localparam int ROB_DEPTH_DEF = 8;
	localparam int BR_SLOTS_DEF  = 4;

	// --------------------
	typedef logic [4:0]  log_reg_t;   // logical register number
	typedef logic [5:0]  phys_tag_t;  // physical register tag
	typedef logic [4:0]  fl_ptr_t;    // free list position, msb is the wrap bit
	typedef logic [2:0]  rob_idx_t;   // reorder buffer entry
	typedef logic [1:0]  br_slot_t;   // checkpoint slot
	typedef logic [3:0]  br_vec_t;    // one bit per checkpoint slot
	typedef logic [31:0] pc_t;

	// outcome of a branch completing this cycle
	typedef enum logic [1:0] {
		br_none  = 2'd0,
		br_right = 2'd1,
		br_wrong = 2'd2
	} br_state_e;

endpackage

// File: src/free_list.sv
// free list, ring of unused physical tags with head restore on branch recovery
module free_list #(
	parameter int NUM_PHYS = rename_pkg::NUM_PHYS_DEF,
	parameter int NUM_ARCH = rename_pkg::NUM_ARCH_DEF
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 pop_i,           // dispatch takes head tag
	input  logic                 push_i,          // retire returns a tag
	input  rename_pkg::phys_tag_t push_tag_i,
	input  logic                 restore_i,       // mispredict recovery
	input  rename_pkg::fl_ptr_t  restore_head_i,
	output rename_pkg::fl_ptr_t  head_o,
	output rename_pkg::phys_tag_t tag_o,
	output logic                 empty_o
);

	localparam int FL_DEPTH = NUM_PHYS - NUM_ARCH;
	localparam int FL_AW    = $clog2(FL_DEPTH);

	rename_pkg::phys_tag_t ring_r [FL_DEPTH];
	rename_pkg::fl_ptr_t   head_r;
	rename_pkg::fl_ptr_t   tail_r;

	// same index and same wrap bit means nothing left to hand out
	assign empty_o = (head_r == tail_r);
	assign head_o  = head_r;
	assign tag_o   = ring_r[head_r[FL_AW-1:0]];

	// --------------------
	// pointers and ring
	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			tail_r <= rename_pkg::fl_ptr_t'(FL_DEPTH);  // full, wrap bits differ
			for (int i = 0; i < FL_DEPTH; i++) begin
				ring_r[i] <= rename_pkg::phys_tag_t'(NUM_ARCH + i);
			end
		end else begin
			// restored head gives back every tag popped after the branch
			if (restore_i) begin
				head_r <= restore_head_i;
			end else if (pop_i) begin
				head_r <= head_r + rename_pkg::fl_ptr_t'(1);
			end

			if (push_i) begin
				ring_r[tail_r[FL_AW-1:0]] <= push_tag_i;
				tail_r                    <= tail_r + rename_pkg::fl_ptr_t'(1);
			end
		end
	end

endmodule

// File: src/rename_map.sv
// rename map, logical to physical translation with per-branch checkpoints
module rename_map #(
	parameter int NUM_ARCH = rename_pkg::NUM_ARCH_DEF,
	parameter int BR_SLOTS = rename_pkg::BR_SLOTS_DEF
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 rename_i,       // accepted dispatch
	input  rename_pkg::log_reg_t  dest_i,
	input  rename_pkg::phys_tag_t new_tag_i,
	input  logic                 is_br_i,
	output rename_pkg::phys_tag_t old_tag_o,
	output rename_pkg::br_slot_t  slot_o,
	output logic                 slot_full_o,
	input  logic                 resolve_i,      // branch predicted right
	input  rename_pkg::br_slot_t  resolve_slot_i,
	input  logic                 recover_i       // branch predicted wrong
);

	rename_pkg::phys_tag_t map_r   [NUM_ARCH];
	rename_pkg::phys_tag_t map_nxt [NUM_ARCH];
	rename_pkg::phys_tag_t cp_map_r  [BR_SLOTS][NUM_ARCH];
	rename_pkg::br_vec_t   cp_busy_r [BR_SLOTS];
	rename_pkg::br_vec_t   busy_r;
	rename_pkg::br_vec_t   clr_vec;
	rename_pkg::br_vec_t   alloc_vec;
	logic                  alloc;

	assign old_tag_o   = map_r[dest_i];
	assign slot_full_o = &busy_r[BR_SLOTS-1:0];
	assign alloc       = rename_i & is_br_i;

	// lowest free slot wins
	always_comb begin
		slot_o = '0;
		for (int i = BR_SLOTS - 1; i >= 0; i--) begin
			if (!busy_r[i])
				slot_o = rename_pkg::br_slot_t'(i);
		end
	end

	assign clr_vec   = resolve_i ? (rename_pkg::br_vec_t'(1) << resolve_slot_i) : '0;
	assign alloc_vec = alloc ? (rename_pkg::br_vec_t'(1) << slot_o) : '0;

	// map with this cycle's rename applied, the branch checkpoint includes its own dest
	always_comb begin
		map_nxt = map_r;
		if (rename_i)
			map_nxt[dest_i] = new_tag_i;
	end

	// --------------------
	// current map and busy slots
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_ARCH; i++) begin
				map_r[i] <= rename_pkg::phys_tag_t'(i);  // identity
			end
			busy_r <= '0;
			for (int s = 0; s < BR_SLOTS; s++) begin
				cp_busy_r[s] <= '0;
			end
		end else if (recover_i) begin
			// drops the branch's own slot and every younger one
			map_r  <= cp_map_r[resolve_slot_i];
			busy_r <= cp_busy_r[resolve_slot_i];
		end else begin
			map_r  <= map_nxt;
			busy_r <= (busy_r & ~clr_vec) | alloc_vec;
			// a resolved slot must not come back with a later recovery
			for (int s = 0; s < BR_SLOTS; s++) begin
				cp_busy_r[s] <= cp_busy_r[s] & ~clr_vec;
			end
			if (alloc)
				cp_busy_r[slot_o] <= busy_r & ~clr_vec;
		end
	end

	// checkpoint copies of the map
	always_ff @(posedge clk) begin
		if (alloc)
			cp_map_r[slot_o] <= map_nxt;
	end

endmodule

// File: src/rob.sv
// reorder buffer that retires renamed instructions in order with early branch recovery
module rob #(
	parameter int ROB_DEPTH = rename_pkg::ROB_DEPTH_DEF
) (
	input  logic                  clk,
	input  logic                  rst,

	// --------------------
	// dispatch
	input  logic                  dispatch_i,
	input  rename_pkg::log_reg_t  dest_i,
	input  rename_pkg::phys_tag_t new_tag_i,
	input  rename_pkg::phys_tag_t old_tag_i,
	input  rename_pkg::fl_ptr_t   fl_head_i,     // free list head before the pop
	input  rename_pkg::pc_t       pc_i,
	input  logic                  is_br_i,
	input  logic                  pretaken_i,
	input  rename_pkg::br_slot_t  slot_i,
	output rename_pkg::rob_idx_t  tail_idx_o,
	output logic                  full_o,

	// --------------------
	// completion
	input  logic                  fu_done_i,
	input  rename_pkg::rob_idx_t  fu_idx_i,
	input  logic                  fu_br_taken_i,
	output rename_pkg::br_state_e br_state_o,
	output logic                  recover_o,
	output rename_pkg::fl_ptr_t   recover_fl_head_o,
	output rename_pkg::br_slot_t  resolve_slot_o,

	// --------------------
	// retire
	output logic                  retire_valid_o,
	output rename_pkg::log_reg_t  retire_dest_o,
	output rename_pkg::phys_tag_t retire_phys_o,
	output rename_pkg::phys_tag_t retire_freed_o
);

	localparam int IDX_W = $clog2(ROB_DEPTH);
	localparam int PTR_W = IDX_W + 1;

	// entry payload
	rename_pkg::log_reg_t  dest_r     [ROB_DEPTH];
	rename_pkg::phys_tag_t new_tag_r  [ROB_DEPTH];
	rename_pkg::phys_tag_t old_tag_r  [ROB_DEPTH];
	rename_pkg::fl_ptr_t   fl_head_r  [ROB_DEPTH];
	rename_pkg::br_slot_t  slot_r     [ROB_DEPTH];
	logic [ROB_DEPTH-1:0]  is_br_r;
	logic [ROB_DEPTH-1:0]  pretaken_r;
	logic [ROB_DEPTH-1:0]  done_r;

	logic [PTR_W-1:0]      head_r;
	logic [PTR_W-1:0]      tail_r;
	logic [PTR_W-1:0]      recover_tail;
	logic [IDX_W-1:0]      head_ix;
	logic [IDX_W-1:0]      tail_ix;
	logic [IDX_W-1:0]      fu_ix;
	logic [IDX_W-1:0]      br_ofs;
	logic                  empty;

	assign head_ix = head_r[IDX_W-1:0];
	assign tail_ix = tail_r[IDX_W-1:0];
	assign fu_ix   = IDX_W'(fu_idx_i);

	assign empty      = (head_r == tail_r);
	assign tail_idx_o = rename_pkg::rob_idx_t'(tail_ix);

	// a retiring head frees its slot for a dispatch in the same cycle
	assign full_o = (head_ix == tail_ix) && (head_r[IDX_W] != tail_r[IDX_W])
		&& !retire_valid_o;

	// --------------------
	// retire
	assign retire_valid_o = !empty && done_r[head_ix];  // squashed done bits sit past the tail
	assign retire_dest_o  = dest_r[head_ix];
	assign retire_phys_o  = new_tag_r[head_ix];
	assign retire_freed_o = old_tag_r[head_ix];

	// --------------------
	// branch resolve
	always_comb begin
		br_state_o = rename_pkg::br_none;
		if (fu_done_i && is_br_r[fu_ix]) begin
			br_state_o = (pretaken_r[fu_ix] == fu_br_taken_i) ?
				rename_pkg::br_right : rename_pkg::br_wrong;
		end
	end

	assign recover_o         = (br_state_o == rename_pkg::br_wrong);
	assign recover_fl_head_o = fl_head_r[fu_ix] + rename_pkg::fl_ptr_t'(1);  // keep branch's tag
	assign resolve_slot_o    = slot_r[fu_ix];

	// offset from the head keeps the wrap bit right
	assign br_ofs       = fu_ix - head_ix;
	assign recover_tail = head_r + PTR_W'(br_ofs) + PTR_W'(1);

	// entry payload written at the tail
	always_ff @(posedge clk) begin
		if (dispatch_i) begin
			dest_r[tail_ix]     <= dest_i;
			new_tag_r[tail_ix]  <= new_tag_i;
			old_tag_r[tail_ix]  <= old_tag_i;
			fl_head_r[tail_ix]  <= fl_head_i;
			slot_r[tail_ix]     <= slot_i;
			is_br_r[tail_ix]    <= is_br_i;
			pretaken_r[tail_ix] <= pretaken_i;
		end
	end

	// pointers and done bits
	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			tail_r <= '0;
			done_r <= '0;
		end else begin
			if (retire_valid_o) begin
				head_r          <= head_r + PTR_W'(1);
				done_r[head_ix] <= 1'b0;
			end
			if (fu_done_i)
				done_r[fu_ix] <= 1'b1;
			if (dispatch_i)
				done_r[tail_ix] <= 1'b0;  // fresh entry

			if (recover_o)
				tail_r <= recover_tail;   // squash everything younger
			else if (dispatch_i)
				tail_r <= tail_r + PTR_W'(1);
		end
	end

endmodule

// File: src/rename_core_top.sv
// rename and retire core, joins free list, rename map and reorder buffer
module rename_core_top #(
	parameter int NUM_PHYS  = rename_pkg::NUM_PHYS_DEF,
	parameter int NUM_ARCH  = rename_pkg::NUM_ARCH_DEF,
	parameter int ROB_DEPTH = rename_pkg::ROB_DEPTH_DEF,
	parameter int BR_SLOTS  = rename_pkg::BR_SLOTS_DEF
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  dispatch_valid_i,
	input  rename_pkg::log_reg_t  dispatch_dest_i,
	input  rename_pkg::pc_t       dispatch_pc_i,
	input  logic                  dispatch_br_i,
	input  logic                  dispatch_pretaken_i,
	output logic                  dispatch_stall_o,
	output rename_pkg::rob_idx_t  dispatch_rob_idx_o,
	output rename_pkg::phys_tag_t dispatch_phys_o,
	input  logic                  fu_done_i,
	input  rename_pkg::rob_idx_t  fu_idx_i,
	input  logic                  fu_br_taken_i,
	output rename_pkg::br_state_e br_state_o,
	output logic                  recover_o,
	output logic                  retire_valid_o,
	output rename_pkg::log_reg_t  retire_dest_o,
	output rename_pkg::phys_tag_t retire_phys_o,
	output rename_pkg::phys_tag_t retire_freed_o
);

	rename_pkg::fl_ptr_t   fl_head;
	rename_pkg::fl_ptr_t   recover_fl_head;
	rename_pkg::phys_tag_t old_tag;
	rename_pkg::br_slot_t  br_slot;
	rename_pkg::br_slot_t  resolve_slot;
	logic                  fl_empty;
	logic                  slot_full;
	logic                  rob_full;
	logic                  accept;
	logic                  resolve_right;

	// --------------------
	// dispatch control
	assign dispatch_stall_o = rob_full | fl_empty | (dispatch_br_i & slot_full)
		| recover_o;                                     // hold off during recovery
	assign accept        = dispatch_valid_i & ~dispatch_stall_o;
	assign resolve_right = (br_state_o == rename_pkg::br_right);

	free_list #(.NUM_PHYS(NUM_PHYS), .NUM_ARCH(NUM_ARCH)) u_free_list (
		.clk            (clk),
		.rst            (rst),
		.pop_i          (accept),
		.push_i         (retire_valid_o),
		.push_tag_i     (retire_freed_o),   // old mapping goes back
		.restore_i      (recover_o),
		.restore_head_i (recover_fl_head),
		.head_o         (fl_head),
		.tag_o          (dispatch_phys_o),
		.empty_o        (fl_empty)
	);

	rename_map #(.NUM_ARCH(NUM_ARCH), .BR_SLOTS(BR_SLOTS)) u_rename_map (
		.clk            (clk),
		.rst            (rst),
		.rename_i       (accept),
		.dest_i         (dispatch_dest_i),
		.new_tag_i      (dispatch_phys_o),
		.is_br_i        (dispatch_br_i),
		.old_tag_o      (old_tag),
		.slot_o         (br_slot),
		.slot_full_o    (slot_full),
		.resolve_i      (resolve_right),
		.resolve_slot_i (resolve_slot),
		.recover_i      (recover_o)
	);

	rob #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
		.clk               (clk),
		.rst               (rst),
		.dispatch_i        (accept),
		.dest_i            (dispatch_dest_i),
		.new_tag_i         (dispatch_phys_o),
		.old_tag_i         (old_tag),
		.fl_head_i         (fl_head),
		.pc_i              (dispatch_pc_i),
		.is_br_i           (dispatch_br_i),
		.pretaken_i        (dispatch_pretaken_i),
		.slot_i            (br_slot),
		.tail_idx_o        (dispatch_rob_idx_o),
		.full_o            (rob_full),
		.fu_done_i         (fu_done_i),
		.fu_idx_i          (fu_idx_i),
		.fu_br_taken_i     (fu_br_taken_i),
		.br_state_o        (br_state_o),
		.recover_o         (recover_o),
		.recover_fl_head_o (recover_fl_head),
		.resolve_slot_o    (resolve_slot),
		.retire_valid_o    (retire_valid_o),
		.retire_dest_o     (retire_dest_o),
		.retire_phys_o     (retire_phys_o),
		.retire_freed_o    (retire_freed_o)
	);

endmodule

// File: verification/clock_gen.sv
// testbench clock and reset source, free-running clock with reset held for a few cycles
module clock_gen #(
	parameter int PERIOD     = 20,
	parameter int RST_CYCLES = 2
) (
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		#2 rst = 1'b0;  // released like any other input
	end

	always #(PERIOD / 2) clk = ~clk;

endmodule

// File: verification/rename_core_tb.sv
// testbench for the rename and retire core that checks a table of steps against a rename model
module rename_core_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int DEPTH     = 8;
	localparam int NUM_STEPS = 45;

	localparam logic [2:0] K_IDLE  = 3'd0;
	localparam logic [2:0] K_DISP  = 3'd1;
	localparam logic [2:0] K_DONE  = 3'd2;  // complete instruction by dispatch number
	localparam logic [2:0] K_RAND  = 3'd3;  // complete a random pending non-branch
	localparam logic [2:0] K_DRAIN = 3'd4;  // idle until everything retired

	localparam rename_pkg::br_state_e BN = rename_pkg::br_none;
	localparam rename_pkg::br_state_e BR = rename_pkg::br_right;
	localparam rename_pkg::br_state_e BW = rename_pkg::br_wrong;

	typedef struct packed {
		logic [2:0]            kind;
		logic [2:0]            test;
		rename_pkg::log_reg_t  dest;
		logic                  br;
		logic                  taken;   // prediction on dispatch, outcome on completion
		logic [7:0]            num;
		rename_pkg::br_state_e exp_br;
	} step_t;

	typedef struct packed {
		logic [7:0]            num;
		rename_pkg::rob_idx_t  idx;
		rename_pkg::log_reg_t  dest;
		rename_pkg::phys_tag_t phys;
		rename_pkg::phys_tag_t old;
		logic                  br;
		logic                  done;
	} entry_t;

	// --------------------
	// kind, test, dest, branch, taken, number, expected branch state
	localparam step_t STEPS [NUM_STEPS] = '{
		'{K_DISP, 3'd1, 5'd1, 1'b0, 1'b0, 8'd0, BN},
		'{K_DISP, 3'd1, 5'd2, 1'b0, 1'b0, 8'd0, BN},
		'{K_DISP, 3'd1, 5'd1, 1'b0, 1'b0, 8'd0, BN},
		'{K_RAND, 3'd2, 5'd0, 1'b0, 1'b0, 8'd0, BN},
		'{K_RAND, 3'd2, 5'd0, 1'b0, 1'b0, 8'd0, BN},
		'{K_RAND, 3'd2, 5'd0, 1'b0, 1'b0, 8'd0, BN},
		'{K_DRAIN, 3'd2, 5'd0, 1'b0, 1'b0, 8'd0, BN},
		'{K_DISP, 3'd3, 5'd3, 1'b0, 1'b0, 8'd0, BN},
		'{K_DISP, 3'd3, 5'd4, 1'b0, 1'b0, 8'd0, BN},
		'{K_DISP, 3'd3, 5'd5, 1'b0, 1'b0, 8'd0, BN},
		'{K_DISP, 3'd3, 5'd6, 1'b0, 1'b0, 8'd0, BN},
		'{K_DISP, 3'd3, 5'd7, 1'b0, 1'b0, 8'd0, BN},
		'{K_DISP, 3'd3, 5'd8, 1'b0, 1'b0, 8'd0, BN},
		'{K_DISP, 3'd3, 5'd9, 1'b0, 1'b0, 8'd0, BN},
		'{K_DISP, 3'd3, 5'd10, 1'b0, 1'b0, 8'd0, BN},
		'{K_DISP, 3'd3, 5'd11, 1'b0, 1'b0, 8'd0, BN},   // rob full so this one stalls
		'{K_DONE, 3'd3, 5'd0, 1'b0, 1'b0, 8'd3, BN},
		'{K_DISP, 3'd3, 5'd11, 1'b0, 1'b0, 8'd0, BN},   // goes in with the retire
		'{K_RAND, 3'd3, 5'd0, 1'b0, 1'b0, 8'd0, BN},
		'{K_RAND, 3'd3, 5'd0, 1'b0, 1'b0, 8'd0, BN},
		'{K_RAND, 3'd3, 5'd0, 1'b0, 1'b0, 8'd0, BN},
		'{K_RAND, 3'd3, 5'd0, 1'b0, 1'b0, 8'd0, BN},
		'{K_RAND, 3'd3, 5'd0, 1'b0, 1'b0, 8'd0, BN},
		'{K_RAND, 3'd3, 5'd0, 1'b0, 1'b0, 8'd0, BN},
		'{K_RAND, 3'd3, 5'd0, 1'b0, 1'b0, 8'd0, BN},
		'{K_RAND, 3'd3, 5'd0, 1'b0, 1'b0, 8'd0, BN},
		'{K_DRAIN, 3'd3, 5'd0, 1'b0, 1'b0, 8'd0, BN},
		'{K_DISP, 3'd4, 5'd12, 1'b1, 1'b1, 8'd0, BN},
		'{K_DISP, 3'd4, 5'd13, 1'b0, 1'b0, 8'd0, BN},
		'{K_DISP, 3'd4, 5'd12, 1'b0, 1'b0, 8'd0, BN},
		'{K_DONE, 3'd4, 5'd0, 1'b0, 1'b1, 8'd12, BR},
		'{K_RAND, 3'd4, 5'd0, 1'b0, 1'b0, 8'd0, BN},
		'{K_RAND, 3'd4, 5'd0, 1'b0, 1'b0, 8'd0, BN},
		'{K_DRAIN, 3'd4, 5'd0, 1'b0, 1'b0, 8'd0, BN},
		'{K_DISP, 3'd5, 5'd5, 1'b0, 1'b0, 8'd0, BN},
		'{K_DISP, 3'd5, 5'd14, 1'b1, 1'b0, 8'd0, BN},
		'{K_DISP, 3'd5, 5'd5, 1'b0, 1'b0, 8'd0, BN},
		'{K_DISP, 3'd5, 5'd6, 1'b0, 1'b0, 8'd0, BN},
		'{K_DONE, 3'd5, 5'd0, 1'b0, 1'b1, 8'd16, BW},
		'{K_DISP, 3'd5, 5'd7, 1'b0, 1'b0, 8'd0, BN},    // reuses first squashed tag
		'{K_DISP, 3'd5, 5'd5, 1'b0, 1'b0, 8'd0, BN},    // frees the pre-branch mapping
		'{K_RAND, 3'd5, 5'd0, 1'b0, 1'b0, 8'd0, BN},
		'{K_RAND, 3'd5, 5'd0, 1'b0, 1'b0, 8'd0, BN},
		'{K_RAND, 3'd5, 5'd0, 1'b0, 1'b0, 8'd0, BN},
		'{K_DRAIN, 3'd5, 5'd0, 1'b0, 1'b0, 8'd0, BN}
	};

	logic                  clk;
	logic                  rst;
	logic                  dispatch_valid_i;
	rename_pkg::log_reg_t  dispatch_dest_i;
	rename_pkg::pc_t       dispatch_pc_i;
	logic                  dispatch_br_i;
	logic                  dispatch_pretaken_i;
	logic                  dispatch_stall_o;
	rename_pkg::rob_idx_t  dispatch_rob_idx_o;
	rename_pkg::phys_tag_t dispatch_phys_o;
	logic                  fu_done_i;
	rename_pkg::rob_idx_t  fu_idx_i;
	logic                  fu_br_taken_i;
	rename_pkg::br_state_e br_state_o;
	logic                  recover_o;
	logic                  retire_valid_o;
	rename_pkg::log_reg_t  retire_dest_o;
	rename_pkg::phys_tag_t retire_phys_o;
	rename_pkg::phys_tag_t retire_freed_o;
	logic                  deep_valid_i;
	rename_pkg::log_reg_t  deep_dest_i;
	logic                  deep_stall_o;
	rename_pkg::phys_tag_t deep_phys_o;

	// reference model state
	entry_t                rob_q [$];
	rename_pkg::phys_tag_t fl_q [$];
	rename_pkg::phys_tag_t map_m [32];
	rename_pkg::rob_idx_t  next_idx;
	logic [7:0]            next_num;
	int                    errors;
	int                    checks;
	int                    test_errors;
	int                    cycles = 0;

	clock_gen #(.PERIOD(20), .RST_CYCLES(2)) u_clock_gen (.clk(clk), .rst(rst));

	rename_core_top #(.ROB_DEPTH(DEPTH)) i_dut (
		.clk                 (clk),
		.rst                 (rst),
		.dispatch_valid_i    (dispatch_valid_i),
		.dispatch_dest_i     (dispatch_dest_i),
		.dispatch_pc_i       (dispatch_pc_i),
		.dispatch_br_i       (dispatch_br_i),
		.dispatch_pretaken_i (dispatch_pretaken_i),
		.dispatch_stall_o    (dispatch_stall_o),
		.dispatch_rob_idx_o  (dispatch_rob_idx_o),
		.dispatch_phys_o     (dispatch_phys_o),
		.fu_done_i           (fu_done_i),
		.fu_idx_i            (fu_idx_i),
		.fu_br_taken_i       (fu_br_taken_i),
		.br_state_o          (br_state_o),
		.recover_o           (recover_o),
		.retire_valid_o      (retire_valid_o),
		.retire_dest_o       (retire_dest_o),
		.retire_phys_o       (retire_phys_o),
		.retire_freed_o      (retire_freed_o)
	);

	// deep rob so that only the free list can run out
	rename_core_top #(.ROB_DEPTH(32)) i_dut_deep (
		.clk                 (clk),
		.rst                 (rst),
		.dispatch_valid_i    (deep_valid_i),
		.dispatch_dest_i     (deep_dest_i),
		.dispatch_pc_i       (32'h0),
		.dispatch_br_i       (1'b0),
		.dispatch_pretaken_i (1'b0),
		.dispatch_stall_o    (deep_stall_o),
		.dispatch_rob_idx_o  (),
		.dispatch_phys_o     (deep_phys_o),
		.fu_done_i           (1'b0),
		.fu_idx_i            (3'd0),
		.fu_br_taken_i       (1'b0),
		.br_state_o          (),
		.recover_o           (),
		.retire_valid_o      (),
		.retire_dest_o       (),
		.retire_phys_o       (),
		.retire_freed_o      ()
	);

	// --------------------
	// compare tasks
	task automatic check_tag(input string name, input rename_pkg::phys_tag_t got,
		input rename_pkg::phys_tag_t exp);
		checks++;
		if (got !== exp) begin
			$display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_reg(input string name, input rename_pkg::log_reg_t got,
		input rename_pkg::log_reg_t exp);
		checks++;
		if (got !== exp) begin
			$display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_idx(input string name, input rename_pkg::rob_idx_t got,
		input rename_pkg::rob_idx_t exp);
		checks++;
		if (got !== exp) begin
			$display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_br(input string name, input rename_pkg::br_state_e got,
		input rename_pkg::br_state_e exp);
		checks++;
		if (got !== exp) begin
			$display("ERROR %0t %s got %s expected %s", $time, name, got.name(), exp.name());
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	// --------------------
	// model helpers
	function automatic int find_pos(input logic [7:0] num);
		for (int i = 0; i < rob_q.size(); i++) begin
			if (rob_q[i].num == num)
				return i;
		end
		return -1;
	endfunction

	function automatic int pick_pending();
		int cand [$];
		for (int i = 0; i < rob_q.size(); i++) begin
			if (!rob_q[i].br && !rob_q[i].done)
				cand.push_back(i);
		end
		if (cand.size() == 0)
			return -1;
		return cand[$urandom % cand.size()];
	endfunction

	// one clock cycle that drives after the edge, checks at the falling edge and steps the model
	task automatic run_step(input step_t s);
		int                    pos;
		logic                  exp_ret;
		logic                  exp_rec;
		logic                  exp_stall;
		logic                  acc;
		entry_t                e;
		rename_pkg::br_state_e exp_state;
		pos = -1;
		@(posedge clk);
		#2;
		if (s.kind == K_DONE)
			pos = find_pos(s.num);
		else if (s.kind == K_RAND)
			pos = pick_pending();
		if (s.kind == K_DONE && pos < 0) begin
			$display("table row at %0t completes instruction %0d, not in flight", $time, s.num);
			errors++;
		end
		dispatch_valid_i    = (s.kind == K_DISP);
		dispatch_dest_i     = s.dest;
		dispatch_br_i       = s.br;
		dispatch_pretaken_i = s.taken;
		dispatch_pc_i       = $urandom;
		fu_done_i           = (pos >= 0);
		fu_idx_i            = (pos >= 0) ? rob_q[pos].idx : '0;
		fu_br_taken_i       = s.taken;
		@(negedge clk);

		exp_ret   = (rob_q.size() > 0) && rob_q[0].done;
		exp_rec   = (pos >= 0) && (s.exp_br == BW);
		exp_stall = ((rob_q.size() == DEPTH) && !exp_ret) || (fl_q.size() == 0) || exp_rec;
		exp_state = (pos >= 0) ? s.exp_br : BN;
		acc       = dispatch_valid_i && !exp_stall;
		check_bit("dispatch_stall_o", dispatch_stall_o, exp_stall);
		check_bit("retire_valid_o", retire_valid_o, exp_ret);
		check_bit("recover_o", recover_o, exp_rec);
		check_br("br_state_o", br_state_o, exp_state);
		if (exp_ret) begin
			check_reg("retire_dest_o", retire_dest_o, rob_q[0].dest);
			check_tag("retire_phys_o", retire_phys_o, rob_q[0].phys);
			check_tag("retire_freed_o", retire_freed_o, rob_q[0].old);
		end
		if (acc) begin
			check_tag("dispatch_phys_o", dispatch_phys_o, fl_q[0]);
			check_idx("dispatch_rob_idx_o", dispatch_rob_idx_o, next_idx);
		end

		if (pos >= 0) begin
			e         = rob_q[pos];
			e.done    = 1'b1;
			rob_q[pos] = e;
			if (exp_rec) begin
				// undo younger renames youngest first and hand their tags back in order
				while (rob_q.size() > pos + 1) begin
					e = rob_q.pop_back();
					map_m[e.dest] = e.old;
					fl_q.push_front(e.phys);
				end
				next_idx = rob_q[pos].idx + rename_pkg::rob_idx_t'(1);
			end
		end
		if (exp_ret) begin
			e = rob_q.pop_front();
			fl_q.push_back(e.old);
		end
		if (acc) begin
			e.num         = next_num;
			e.idx         = next_idx;
			e.dest        = s.dest;
			e.phys        = fl_q.pop_front();
			e.old         = map_m[s.dest];
			e.br          = s.br;
			e.done        = 1'b0;
			map_m[s.dest] = e.phys;
			rob_q.push_back(e);
			next_num++;
			next_idx++;
		end
	endtask

	task automatic drain_rob();
		step_t idle;
		idle      = '0;
		idle.kind = K_IDLE;
		while (rob_q.size() > 0)
			run_step(idle);
	endtask

	// sixteen renames on the deep instance empty its free list
	task automatic fill_free_list();
		for (int i = 0; i <= 16; i++) begin
			@(posedge clk);
			#2;
			deep_valid_i = 1'b1;
			deep_dest_i  = rename_pkg::log_reg_t'(i);
			@(negedge clk);
			check_bit("deep dispatch_stall_o", deep_stall_o, i == 16);
			if (i < 16)
				check_tag("deep dispatch_phys_o", deep_phys_o, rename_pkg::phys_tag_t'(32 + i));
		end
		@(posedge clk);
		#2;
		deep_valid_i = 1'b0;
		$display("test 6 finished, %0d errors", errors - test_errors);
		test_errors = errors;
	endtask

	// --------------------
	// hang guard
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= 4 * NUM_STEPS + 50) begin
			$display("timeout, the run did not finish within %0d cycles", 4 * NUM_STEPS + 50);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'hf804));
		dispatch_valid_i    = 1'b0;
		dispatch_dest_i     = '0;
		dispatch_pc_i       = '0;
		dispatch_br_i       = 1'b0;
		dispatch_pretaken_i = 1'b0;
		fu_done_i           = 1'b0;
		fu_idx_i            = '0;
		fu_br_taken_i       = 1'b0;
		deep_valid_i        = 1'b0;
		deep_dest_i         = '0;
		errors      = 0;
		checks      = 0;
		test_errors = 0;
		next_idx    = '0;
		next_num    = '0;
		for (int r = 0; r < 32; r++)
			map_m[r] = rename_pkg::phys_tag_t'(r);       // identity after reset
		for (int t = 32; t < 48; t++)
			fl_q.push_back(rename_pkg::phys_tag_t'(t));

		@(negedge rst);
		for (int i = 0; i < NUM_STEPS; i++) begin
			if (STEPS[i].kind == K_DRAIN)
				drain_rob();
			else
				run_step(STEPS[i]);
			if (i == NUM_STEPS - 1 || STEPS[i + 1].test != STEPS[i].test) begin
				$display("test %0d finished, %0d errors", STEPS[i].test, errors - test_errors);
				test_errors = errors;
			end
		end
		fill_free_list();

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: verilog.f
src/rename_pkg.sv
src/free_list.sv
src/rename_map.sv
src/rob.sv
src/rename_core_top.sv
verification/clock_gen.sv
verification/rename_core_tb.sv

// File: Makefile
.PHONY: simulate clean

simulate:
	verilator --binary --timing -j 0 --top-module rename_core_tb -f verilog.f
	./obj_dir/Vrename_core_tb | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
